//--- Bender.yml
package:
  name: spi_flash_ctrl

sources:
  # Controller RTL, package first
  - include_dirs:
      - verilog
    files:
      - verilog/spi_flash_pkg.sv
      - verilog/spi_byte_shifter.sv
      - verilog/flash_cmd_sequencer.sv
      - verilog/spi_flash_ctrl.sv
  # Flash die model and testbench
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/flash_spi_model.sv
      - sim/tb_spi_flash_ctrl.sv

//--- sim/flash_spi_model.sv
/*
  Behavioral flash die for READ_ID, RDSR1, WREN, READ3 and PP3, SPI mode 0.
  No page wrap and no program delay. Unwritten bytes read a pattern of the
  whole address; status register holds WEL only.
*/
`timescale 1ns/100ps
`default_nettype none

module flash_spi_model (
  input  wire logic                flash_sck,
  input  wire logic                flash_cs_n,
  input  wire logic                flash_si,
  output logic                     flash_so,
  output spi_flash_pkg::flash_op_e seen_op
);

  import spi_flash_pkg::*;

  logic [7:0]  in_shift;
  // Byte shifted out on the next SO frame
  logic [7:0]  out_byte;
  logic [7:0]  opcode;
  logic [23:0] addr;
  // Write enable latch
  logic        wel;
  int          bit_cnt;
  int          byte_idx;
  // Programmed bytes, newest last
  logic [23:0] prog_addr [$];
  logic [7:0]  prog_data [$];

  // Newest programmed value wins, else the erased pattern
  function automatic logic [7:0] mem_read(input logic [23:0] a);
    for (int i = prog_addr.size() - 1; i >= 0; i--) begin
      if (prog_addr[i] == a) begin
        return prog_data[i];
      end
    end
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
  endfunction

  initial begin
    flash_so = 1'b0;
    seen_op  = OP_READ_ID;
    in_shift = '0;
    out_byte = '0;
    opcode   = '0;
    addr     = '0;
    wel      = 1'b0;
    bit_cnt  = 0;
    byte_idx = 0;
  end

  // ####################
  // Byte decode
  // ####################

  task automatic take_byte(input logic [7:0] b);
    if (byte_idx == 0) begin
      // Opcode frame
      opcode   = b;
      out_byte = 8'h00;
      case (b)
        8'h90: seen_op = OP_READ_ID;
        8'h05: begin
          seen_op  = OP_RDSR1;
          out_byte = {6'b0, wel, 1'b0};
        end
        8'h06: begin
          seen_op = OP_WREN;
          wel     = 1'b1;
        end
        8'h03: seen_op = OP_READ3;
        8'h02: seen_op = OP_PP3;
        default: out_byte = 8'h00;
      endcase
    end else if (byte_idx <= 3 && opcode != 8'h05) begin
      // Address, MSB first
      addr = {addr[15:0], b};
      if (byte_idx == 3 && opcode == 8'h90) begin
        out_byte = 8'h01;
      end
      if (byte_idx == 3 && opcode == 8'h03) begin
        out_byte = mem_read(addr);
      end
    end else begin
      case (opcode)
        8'h90: out_byte = (byte_idx == 4) ? 8'h20 : 8'h00;
        // Status repeats while clocked
        8'h05: out_byte = {6'b0, wel, 1'b0};
        8'h03: begin
          addr     = addr + 1'b1;
          out_byte = mem_read(addr);
        end
        8'h02: begin
          if (wel) begin
            prog_addr.push_back(addr);
            prog_data.push_back(b);
          end
          addr = addr + 1'b1;
        end
        default: out_byte = 8'h00;
      endcase
    end
    byte_idx++;
  endtask

  // ####################
  // Pins
  // ####################

  // Frame start
  always @(negedge flash_cs_n) begin
    bit_cnt  = 0;
    byte_idx = 0;
  end

  // Frame end, a program clears WEL
  always @(posedge flash_cs_n) begin
    if (opcode == 8'h02) begin
      wel = 1'b0;
    end
  end

  // SI sampled on rising SCK
  always @(posedge flash_sck) begin
    if (!flash_cs_n) begin
      in_shift = {in_shift[6:0], flash_si};
      bit_cnt++;
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        take_byte(in_shift);
      end
    end
  end

  // SO changes on falling SCK
  always @(negedge flash_sck) begin
    if (!flash_cs_n) begin
      flash_so = out_byte[7 - bit_cnt];
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_spi_flash_ctrl.sv
/*
  Table-driven testbench for the SPI flash controller and one die model.
  Each row runs one command to op_done, then checks a quiet idle window.
  PP3 data comes from $urandom; expected reads follow the die rules.
*/
`timescale 1ns/100ps
`default_nettype none

`include "spi_flash_settings.svh"

module tb_spi_flash_ctrl;

  import spi_flash_pkg::*;

  localparam int BYTE_W = `SPI_FLASH_BYTE_W;
  localparam int LEN_W = `SPI_FLASH_LEN_W;
  localparam int NUM_ROWS = 13;
  // Longest row needs about 340 clocks
  localparam int DONE_TIMEOUT = 2000;
  localparam int IDLE_CYCLES = 20;

  // One command and its fixed expected bytes
  typedef struct packed {
    flash_op_e         op;
    flash_addr_u       addr;
    logic [LEN_W-1:0]  n;
    logic [BYTE_W-1:0] exp0;
    logic [BYTE_W-1:0] exp1;
    // Extra cmd_start while busy
    logic              stray;
  } row_t;

  logic              spi_master_done;
  logic              reset_PP3_send_address_counter;
  logic              cmd_start;
  flash_op_e         cmd_op;
  flash_addr_u       address;
  logic [LEN_W-1:0]  num_bytes;
  logic [BYTE_W-1:0] wr_data;
  logic              busy;
  logic              op_done;
  logic              rd_valid;
  logic [BYTE_W-1:0] rd_data;
  logic              wr_taken;
  logic              flash_sck;
  logic              flash_cs_n;
  logic              flash_si;
  logic              flash_so;
  flash_op_e         seen_op;

  row_t              rows [0:NUM_ROWS-1];
  logic [BYTE_W-1:0] wr_buf [0:511];
  logic [BYTE_W-1:0] rd_q [$];
  // Expected flash contents after programs
  logic [23:0]       shadow_addr [$];
  logic [BYTE_W-1:0] shadow_data [$];
  logic              wel_exp;
  int                value_errors;
  int                protocol_errors;
  int                timeouts;
  int unsigned       seed_draw;

  spi_flash_ctrl i_dut (
    .spi_master_done                (spi_master_done),
    .reset_PP3_send_address_counter (reset_PP3_send_address_counter),
    .cmd_start                      (cmd_start),
    .cmd_op                         (cmd_op),
    .address                        (address),
    .num_bytes                      (num_bytes),
    .wr_data                        (wr_data),
    .busy                           (busy),
    .op_done                        (op_done),
    .rd_valid                       (rd_valid),
    .rd_data                        (rd_data),
    .wr_taken                       (wr_taken),
    .flash_sck                      (flash_sck),
    .flash_cs_n                     (flash_cs_n),
    .flash_si                       (flash_si),
    .flash_so                       (flash_so)
  );

  flash_spi_model i_flash (
    .flash_sck  (flash_sck),
    .flash_cs_n (flash_cs_n),
    .flash_si   (flash_si),
    .flash_so   (flash_so),
    .seen_op    (seen_op)
  );

  // 40 ns clock
  initial begin
    spi_master_done = 1'b0;
    forever #20 spi_master_done = ~spi_master_done;
  end

  // ####################
  // Helpers
  // ####################

  function automatic row_t make_row(input flash_op_e op, input logic [23:0] a, input int n,
                                    input logic [BYTE_W-1:0] e0, input logic [BYTE_W-1:0] e1,
                                    input logic stray);
    row_t r;
    r.op          = op;
    r.addr.linear = a;
    r.n           = LEN_W'(n);
    r.exp0        = e0;
    r.exp1        = e1;
    r.stray       = stray;
    return r;
  endfunction

  // Programmed value if any, else erased pattern of the whole address
  function automatic logic [BYTE_W-1:0] expected_byte(input logic [23:0] a);
    for (int i = shadow_addr.size() - 1; i >= 0; i--) begin
      if (shadow_addr[i] == a) begin
        return shadow_data[i];
      end
    end
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
  endfunction

  task automatic check_byte(input string name, input logic [BYTE_W-1:0] got,
                            input logic [BYTE_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_op(input string name, input flash_op_e got, input flash_op_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %s expected %s", $time, name, got.name(),
               exp.name());
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [LEN_W-1:0] got,
                             input logic [LEN_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // ####################
  // Row runner
  // ####################

  task automatic run_row(input int r);
    row_t row;
    int   cyc;
    int   wr_cnt;
    logic got_done;
    row = rows[r];
    if (row.op == OP_PP3) begin
      for (int i = 0; i < row.n; i++) begin
        wr_buf[i] = BYTE_W'($urandom());
      end
    end
    // One cycle start strobe, first PP3 byte ready up front
    @(posedge spi_master_done);
    cmd_start <= 1'b1;
    cmd_op    <= row.op;
    address   <= row.addr;
    num_bytes <= row.n;
    wr_data   <= wr_buf[0];
    @(posedge spi_master_done);
    cmd_start <= 1'b0;
    rd_q.delete();
    cyc      = 0;
    wr_cnt   = 0;
    got_done = 1'b0;
    while (!got_done && cyc < DONE_TIMEOUT) begin
      @(posedge spi_master_done);
      cyc++;
      // Stray WREN in mid command must be dropped
      if (row.stray && cyc == 10) begin
        cmd_start <= 1'b1;
        cmd_op    <= OP_WREN;
      end
      if (row.stray && cyc == 11) begin
        cmd_start <= 1'b0;
      end
      if (rd_valid) begin
        rd_q.push_back(rd_data);
      end
      if (wr_taken) begin
        wr_cnt++;
        wr_data <= wr_buf[wr_cnt];
      end
      if (!busy && !flash_cs_n) begin
        $display("Chip select low while the controller is idle, row %0d", r);
        protocol_errors++;
      end
      got_done = op_done;
    end
    if (!got_done) begin
      $display("No op_done within %0d clocks for row %0d", DONE_TIMEOUT, r);
      timeouts++;
      return;
    end
    check_op("seen_op", seen_op, row.op);
    case (row.op)
      OP_READ_ID, OP_RDSR1: begin
        check_count("rd_valid count", LEN_W'(rd_q.size()),
                    (row.op == OP_READ_ID) ? LEN_W'(2) : LEN_W'(1));
        if (rd_q.size() > 0) begin
          check_byte("rd_data[0]", rd_q[0], row.exp0);
        end
        if (row.op == OP_READ_ID && rd_q.size() > 1) begin
          check_byte("rd_data[1]", rd_q[1], row.exp1);
        end
      end
      OP_WREN: begin
        check_count("rd_valid count", LEN_W'(rd_q.size()), '0);
        wel_exp = 1'b1;
      end
      OP_READ3: begin
        check_count("rd_valid count", LEN_W'(rd_q.size()), row.n);
        for (int i = 0; i < rd_q.size(); i++) begin
          check_byte($sformatf("rd_data[%0d]", i), rd_q[i],
                     expected_byte(row.addr.linear + 24'(i)));
        end
      end
      default: begin
        check_count("wr_taken count", LEN_W'(wr_cnt), row.n);
        check_count("rd_valid count", LEN_W'(rd_q.size()), '0);
        // Program lands only with WEL set
        for (int i = 0; i < row.n && wel_exp; i++) begin
          shadow_addr.push_back(row.addr.linear + 24'(i));
          shadow_data.push_back(wr_buf[i]);
        end
        wel_exp = 1'b0;
      end
    endcase
    // Nothing may start without a new strobe
    repeat (IDLE_CYCLES) begin
      @(posedge spi_master_done);
      if (busy || op_done || !flash_cs_n) begin
        $display("Controller active after row %0d with no command accepted", r);
        protocol_errors++;
      end
    end
  endtask

  // ####################
  // Main sequence
  // ####################

  initial begin
    seed_draw = $urandom(30341);
    reset_PP3_send_address_counter <= 1'b1;
    cmd_start       <= 1'b0;
    cmd_op          <= OP_READ_ID;
    address         <= '0;
    num_bytes       <= '0;
    wr_data         <= '0;
    wel_exp         = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    rows[0]  = make_row(OP_READ_ID, 24'h000000, 0, 8'h01, 8'h20, 1'b1);
    rows[1]  = make_row(OP_RDSR1, 24'h000000, 0, 8'h00, 8'h00, 1'b0);
    rows[2]  = make_row(OP_READ3, 24'h000100, 8, 8'h00, 8'h00, 1'b0);
    rows[3]  = make_row(OP_READ3, 24'h0012F8, 12, 8'h00, 8'h00, 1'b0);
    rows[4]  = make_row(OP_WREN, 24'h000000, 0, 8'h00, 8'h00, 1'b0);
    rows[5]  = make_row(OP_RDSR1, 24'h000000, 0, 8'h02, 8'h00, 1'b0);
    rows[6]  = make_row(OP_PP3, 24'h000200, 16, 8'h00, 8'h00, 1'b0);
    rows[7]  = make_row(OP_RDSR1, 24'h000000, 0, 8'h00, 8'h00, 1'b0);
    // Stray WREN here would let the next program through
    rows[8]  = make_row(OP_READ3, 24'h000200, 16, 8'h00, 8'h00, 1'b1);
    rows[9]  = make_row(OP_PP3, 24'h000200, 16, 8'h00, 8'h00, 1'b0);
    rows[10] = make_row(OP_READ3, 24'h000200, 16, 8'h00, 8'h00, 1'b0);
    rows[11] = make_row(OP_READ3, 24'h3ABCFE, 4, 8'h00, 8'h00, 1'b1);
    rows[12] = make_row(OP_READ_ID, 24'h000000, 0, 8'h01, 8'h20, 1'b1);
    repeat (5) @(posedge spi_master_done);
    reset_PP3_send_address_counter <= 1'b0;
    repeat (2) @(posedge spi_master_done);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
      if (timeouts != 0) begin
        break;
      end
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout", value_errors, protocol_errors,
             timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- spi_flash_ctrl.f
+incdir+verilog
verilog/spi_flash_pkg.sv
verilog/spi_byte_shifter.sv
verilog/flash_cmd_sequencer.sv
verilog/spi_flash_ctrl.sv
sim/flash_spi_model.sv
sim/tb_spi_flash_ctrl.sv

//--- verilog/flash_cmd_sequencer.sv
/*
  Command FSM for READ_ID, RDSR1, WREN, READ3 and PP3 on one flash die.
  No back-pressure: PP3 data must be ready when wr_taken pulses, and
  cmd_start is ignored while busy. op_done is the last busy cycle.
*/
`timescale 1ns/100ps
`default_nettype none

`include "spi_flash_settings.svh"

module flash_cmd_sequencer (
  input  wire logic                         spi_master_done,
  input  wire logic                         reset_PP3_send_address_counter,
  input  wire logic                         cmd_start,
  input  wire spi_flash_pkg::flash_op_e     cmd_op,
  input  wire spi_flash_pkg::flash_addr_u   address,
  input  wire logic [`SPI_FLASH_LEN_W-1:0]  num_bytes,
  input  wire logic [`SPI_FLASH_BYTE_W-1:0] wr_data,
  input  wire logic                         byte_done,
  input  wire logic [`SPI_FLASH_BYTE_W-1:0] rx_byte,
  output logic                              busy,
  output logic                              op_done,
  output logic                              rd_valid,
  output logic      [`SPI_FLASH_BYTE_W-1:0] rd_data,
  output logic                              wr_taken,
  output logic                              load,
  output logic                              last,
  output logic      [`SPI_FLASH_BYTE_W-1:0] tx_byte
);

  import spi_flash_pkg::*;

  localparam int BYTE_W = `SPI_FLASH_BYTE_W;
  localparam int LEN_W = `SPI_FLASH_LEN_W;
  localparam int ADDR_BYTES = `SPI_FLASH_ADDR_W / `SPI_FLASH_BYTE_W;
  localparam logic [1:0] ADDR_LAST = 2'(ADDR_BYTES - 1);

  // Phase of the frame currently on the wire
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_INSTR = 2'd1;
  localparam logic [1:0] S_ADDR = 2'd2;
  localparam logic [1:0] S_DATA = 2'd3;

  // ####################
  // Registers
  // ####################

  logic [1:0]       state;
  flash_op_e        op_q;
  flash_addr_u      addr_q;
  // Data frames of this operation
  logic [LEN_W-1:0] len_q;
  logic [1:0]       addr_cnt;
  logic [LEN_W-1:0] data_cnt;
  // Instruction frame still to be loaded
  logic             issue;
  // Frame on the wire carries last
  logic             last_inflight;
  logic             op_done_q;

  // Next frame, valid together with load
  logic [1:0]       nxt_state;
  logic [1:0]       nxt_addr_cnt;
  logic [LEN_W-1:0] nxt_data_cnt;
  logic [BYTE_W-1:0] opcode;

  // Opcode of the latched operation
  always_comb begin
    case (op_q)
      OP_READ_ID: opcode = `SPI_FLASH_OP_READ_ID;
      OP_RDSR1:   opcode = `SPI_FLASH_OP_RDSR1;
      OP_WREN:    opcode = `SPI_FLASH_OP_WREN;
      OP_READ3:   opcode = `SPI_FLASH_OP_READ3;
      default:    opcode = `SPI_FLASH_OP_PP3;
    endcase
  end

  // ####################
  // Next frame select
  // ####################

  always_comb begin
    load         = 1'b0;
    last         = 1'b0;
    tx_byte      = '0;
    wr_taken     = 1'b0;
    nxt_state    = state;
    nxt_addr_cnt = addr_cnt;
    nxt_data_cnt = data_cnt;
    if (issue) begin
      // Instruction frame, WREN has nothing after it
      load      = 1'b1;
      tx_byte   = opcode;
      last      = (op_q == OP_WREN);
      nxt_state = S_INSTR;
    end else if (byte_done && !last_inflight) begin
      load = 1'b1;
      case (state)
        S_INSTR: begin
          if (op_q == OP_RDSR1) begin
            // Status byte follows the opcode directly
            nxt_state    = S_DATA;
            nxt_data_cnt = '0;
          end else begin
            nxt_state    = S_ADDR;
            nxt_addr_cnt = '0;
          end
        end
        S_ADDR: begin
          if (addr_cnt == ADDR_LAST) begin
            nxt_state    = S_DATA;
            nxt_data_cnt = '0;
          end else begin
            nxt_addr_cnt = addr_cnt + 1'b1;
          end
        end
        default: begin
          nxt_data_cnt = data_cnt + 1'b1;
        end
      endcase
      if (nxt_state == S_ADDR) begin
        tx_byte = addr_q.bytes[nxt_addr_cnt];
        // Zero length READ3/PP3 ends on the address
        last    = (nxt_addr_cnt == ADDR_LAST) && (len_q == '0);
      end else begin
        // Write data for PP3, dummy zeros while reading
        tx_byte  = (op_q == OP_PP3) ? wr_data : '0;
        wr_taken = (op_q == OP_PP3);
        last     = (nxt_data_cnt == len_q - 1'b1);
      end
    end
  end

  // ####################
  // Control FSM
  // ####################

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      state         <= S_IDLE;
      op_q          <= OP_READ_ID;
      addr_cnt      <= '0;
      data_cnt      <= '0;
      issue         <= 1'b0;
      last_inflight <= 1'b0;
      op_done_q     <= 1'b0;
    end else begin
      issue <= 1'b0;
      if (state == S_IDLE) begin
        if (cmd_start) begin
          state <= S_INSTR;
          op_q  <= cmd_op;
          issue <= 1'b1;
        end
      end else if (op_done_q) begin
        // Done pulse is the final busy cycle
        state     <= S_IDLE;
        op_done_q <= 1'b0;
      end else if (load) begin
        state         <= nxt_state;
        addr_cnt      <= nxt_addr_cnt;
        data_cnt      <= nxt_data_cnt;
        last_inflight <= last;
      end else if (byte_done && last_inflight) begin
        op_done_q <= 1'b1;
      end
    end
  end

  // Command fields, taken at acceptance
  always_ff @(posedge spi_master_done) begin
    if (state == S_IDLE && cmd_start) begin
      // READ_ID sends a zero address
      addr_q.linear <= (cmd_op == OP_READ_ID) ? '0 : address.linear;
      case (cmd_op)
        OP_READ_ID: len_q <= LEN_W'(`SPI_FLASH_ID_BYTES);
        OP_RDSR1:   len_q <= LEN_W'(1);
        OP_WREN:    len_q <= '0;
        default:    len_q <= num_bytes;
      endcase
    end
  end

  // ####################
  // User side
  // ####################

  assign busy     = (state != S_IDLE);
  assign op_done  = op_done_q;
  assign rd_valid = byte_done && (state == S_DATA) && (op_q != OP_PP3);
  assign rd_data  = rx_byte;

  // Done pulse closes the operation on the next clock
  a_done_ends_busy : assert property (
    @(posedge spi_master_done) disable iff (reset_PP3_send_address_counter)
    op_done |-> busy ##1 !busy
  );

  a_rd_wr_exclusive : assert property (
    @(posedge spi_master_done) disable iff (reset_PP3_send_address_counter)
    !(rd_valid && wr_taken)
  );

endmodule

`default_nettype wire

//--- verilog/spi_byte_shifter.sv
/*
  SPI mode 0 byte engine, MSB first, SCK low while idle.
  A load is taken only when idle or in the byte_done cycle; chip select
  stays low between streamed bytes and rises after the byte marked last.
*/
`timescale 1ns/100ps
`default_nettype none

`include "spi_flash_settings.svh"

module spi_byte_shifter (
  input  wire logic                         spi_master_done,
  input  wire logic                         reset_PP3_send_address_counter,
  input  wire logic                         load,
  input  wire logic                         last,
  input  wire logic [`SPI_FLASH_BYTE_W-1:0] tx_byte,
  input  wire logic                         flash_so,
  output logic                              byte_done,
  output logic      [`SPI_FLASH_BYTE_W-1:0] rx_byte,
  output logic                              flash_sck,
  output logic                              flash_cs_n,
  output logic                              flash_si
);

  localparam int BYTE_W = `SPI_FLASH_BYTE_W;
  // Two SCK edges per bit
  localparam int EDGES = 2 * BYTE_W;
  localparam int EDGE_W = $clog2(EDGES);
  localparam int HALF = `SPI_FLASH_SCK_HALF;
  localparam int HALF_W = (HALF > 1) ? $clog2(HALF) : 1;

  // ####################
  // State
  // ####################

  // Byte in flight
  logic              active;
  // SCK edge count within the byte
  logic [EDGE_W-1:0] edge_cnt;
  // Clocks within one SCK half period
  logic [HALF_W-1:0] half_cnt;
  // Current byte closes the frame
  logic              last_q;
  logic [BYTE_W-1:0] tx_shift;
  logic [BYTE_W-1:0] rx_shift;
  logic              sck_q;
  logic              cs_n_q;
  logic              tick;
  logic              accept;

  // End of an SCK half period
  assign tick = (half_cnt == HALF_W'(HALF - 1));

  // Last falling SCK edge of the byte is due
  assign byte_done = active && tick && (edge_cnt == EDGE_W'(EDGES - 1));

  // New byte either from idle or streamed on the end of the previous one
  assign accept = load && (!active || byte_done);

  // ####################
  // Shift control
  // ####################

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      active   <= 1'b0;
      edge_cnt <= '0;
      half_cnt <= '0;
      last_q   <= 1'b0;
      sck_q    <= 1'b0;
      cs_n_q   <= 1'b1;
      tx_shift <= '0;
    end else if (accept) begin
      // MSB goes straight onto SI, first rising edge one half period later
      active   <= 1'b1;
      edge_cnt <= '0;
      half_cnt <= '0;
      last_q   <= last;
      sck_q    <= 1'b0;
      cs_n_q   <= 1'b0;
      tx_shift <= tx_byte;
    end else if (active) begin
      half_cnt <= tick ? '0 : half_cnt + 1'b1;
      if (tick) begin
        sck_q    <= ~sck_q;
        edge_cnt <= edge_cnt + 1'b1;
        // Falling edge, present the next bit
        if (sck_q) begin
          tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
        end
        if (byte_done) begin
          active <= 1'b0;
          // Deselect only after the closing byte
          if (last_q) begin
            cs_n_q <= 1'b1;
          end
        end
      end
    end
  end

  // ####################
  // Receive
  // ####################

  // Capture SO as SCK goes high, flash changes it on the falling edge
  always_ff @(posedge spi_master_done) begin
    if (active && tick && !sck_q) begin
      rx_shift <= {rx_shift[BYTE_W-2:0], flash_so};
    end
  end

  assign rx_byte    = rx_shift;
  assign flash_sck  = sck_q;
  assign flash_cs_n = cs_n_q;
  assign flash_si   = tx_shift[BYTE_W-1];

  // ####################
  // Checks
  // ####################

  // Mode 0 idle level whenever the die is deselected
  a_sck_low_deselected : assert property (
    @(posedge spi_master_done) disable iff (reset_PP3_send_address_counter)
    flash_cs_n |-> !flash_sck
  );

  // Sequencer never loads into a byte that is still shifting
  a_no_load_mid_byte : assert property (
    @(posedge spi_master_done) disable iff (reset_PP3_send_address_counter)
    load |-> (!active || byte_done)
  );

endmodule

`default_nettype wire

//--- verilog/spi_flash_ctrl.sv
/*
  Single die SPI NOR flash controller, SDR mode 0, SCK at clock/2.
  Five commands, 3 byte addressing only; user interface has no stalls.
*/
`timescale 1ns/100ps
`default_nettype none

`include "spi_flash_settings.svh"

module spi_flash_ctrl (
  input  wire logic                         spi_master_done,
  input  wire logic                         reset_PP3_send_address_counter,
  // User command side
  input  wire logic                         cmd_start,
  input  wire spi_flash_pkg::flash_op_e     cmd_op,
  input  wire spi_flash_pkg::flash_addr_u   address,
  input  wire logic [`SPI_FLASH_LEN_W-1:0]  num_bytes,
  input  wire logic [`SPI_FLASH_BYTE_W-1:0] wr_data,
  output logic                              busy,
  output logic                              op_done,
  output logic                              rd_valid,
  output logic      [`SPI_FLASH_BYTE_W-1:0] rd_data,
  output logic                              wr_taken,
  // Flash pins
  output logic                              flash_sck,
  output logic                              flash_cs_n,
  output logic                              flash_si,
  input  wire logic                         flash_so
);

  // Sequencer to shifter handshake
  logic                         load;
  logic                         last;
  logic [`SPI_FLASH_BYTE_W-1:0] tx_byte;
  logic                         byte_done;
  logic [`SPI_FLASH_BYTE_W-1:0] rx_byte;

  flash_cmd_sequencer u_seq (
    .spi_master_done                (spi_master_done),
    .reset_PP3_send_address_counter (reset_PP3_send_address_counter),
    .cmd_start                      (cmd_start),
    .cmd_op                         (cmd_op),
    .address                        (address),
    .num_bytes                      (num_bytes),
    .wr_data                        (wr_data),
    .byte_done                      (byte_done),
    .rx_byte                        (rx_byte),
    .busy                           (busy),
    .op_done                        (op_done),
    .rd_valid                       (rd_valid),
    .rd_data                        (rd_data),
    .wr_taken                       (wr_taken),
    .load                           (load),
    .last                           (last),
    .tx_byte                        (tx_byte)
  );

  // Byte engine on the flash pins
  spi_byte_shifter u_shift (
    .spi_master_done                (spi_master_done),
    .reset_PP3_send_address_counter (reset_PP3_send_address_counter),
    .load                           (load),
    .last                           (last),
    .tx_byte                        (tx_byte),
    .flash_so                       (flash_so),
    .byte_done                      (byte_done),
    .rx_byte                        (rx_byte),
    .flash_sck                      (flash_sck),
    .flash_cs_n                     (flash_cs_n),
    .flash_si                       (flash_si)
  );

endmodule

`default_nettype wire

//--- verilog/spi_flash_pkg.sv
/*
  Operation codes and the address word type for the flash controller.
  Byte view of the address is MSB first, bytes[0] is address[23:16].
*/
`default_nettype none

`include "spi_flash_settings.svh"

package spi_flash_pkg;

  // ####################
  // Operations
  // ####################

  // Commands the user can request
  typedef enum logic [2:0] {
    OP_READ_ID,
    OP_RDSR1,
    OP_WREN,
    OP_READ3,
    OP_PP3
  } flash_op_e;

  // ####################
  // Address word
  // ####################

  // One 24 bit address, seen either whole or as bytes
  // Ascending outer range puts the most significant byte at index 0,
  // which is the order the bytes go out on the wire
  typedef union packed {
    // Byte address as given by the user
    logic [`SPI_FLASH_ADDR_W-1:0] linear;
    // Address phase bytes, indexed by address frame count
    logic [0:(`SPI_FLASH_ADDR_W/`SPI_FLASH_BYTE_W)-1][`SPI_FLASH_BYTE_W-1:0] bytes;
  } flash_addr_u;

endpackage

`default_nettype wire

//--- verilog/spi_flash_settings.svh
/*
  Opcodes, widths and limits shared by the SPI flash controller.
  SCK half period is counted in system clocks; the frame timing in the
  sequencer assumes SPI_FLASH_SCK_HALF of 1 (16 clocks per byte).
*/
`ifndef SPI_FLASH_SETTINGS_SVH
`define SPI_FLASH_SETTINGS_SVH

// ####################
// Widths
// ####################
`define SPI_FLASH_BYTE_W 8
`define SPI_FLASH_ADDR_W 24
// Up to one 512 byte page plus margin
`define SPI_FLASH_LEN_W 10

// ####################
// Flash opcodes
// ####################
`define SPI_FLASH_OP_READ_ID 8'h90
`define SPI_FLASH_OP_RDSR1 8'h05
`define SPI_FLASH_OP_WREN 8'h06
`define SPI_FLASH_OP_READ3 8'h03
`define SPI_FLASH_OP_PP3 8'h02

// ####################
// Limits
// ####################
// Manufacturer and device ID
`define SPI_FLASH_ID_BYTES 2
`define SPI_FLASH_SCK_HALF 1

`endif
